/* design/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = '0;
    // addi x0, x0, 0
    localparam word_t NOP      = 32'h0000_0013;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // Low bits follow funct3, bit 3 is funct7[5]
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_SRA    = 4'b1101,
        ALU_PASS_B = 4'b1111
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_type_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        opcode_e     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        opcode_e    opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     a_pc;
        logic     b_imm;
        br_type_e br_type;
        logic     jal;
        logic     jalr;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        wb_sel_e  wb_sel;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     pc4;
        word_t     rs1_data;
        word_t     rs2_data;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        word_t     imm;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        wb_sel_e   wb_sel;
        word_t     alu_result;
        word_t     store_data;
        word_t     pc4;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        wb_sel_e   wb_sel;
        word_t     alu_result;
        word_t     load_data;
        word_t     pc4;
        reg_addr_t rd;
    } mem_wb_t;

endpackage

/* design/fetch_stage.sv */
module fetch_stage (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           stall_if,
    input  logic           stall_id,
    input  logic           flush_id,
    input  logic           redirect,
    input  rv_pkg::word_t  redirect_pc,
    input  rv_pkg::word_t  im_dout,
    output rv_pkg::word_t  im_addr,
    output rv_pkg::word_t  if_pc,
    output rv_pkg::word_t  if_pc4,
    output rv_pkg::instr_u if_instr
);

    rv_pkg::word_t pc;
    rv_pkg::word_t pc4;
    rv_pkg::word_t pc_next;

    assign im_addr = pc;
    assign pc4     = pc + 32'd4;

    // Redirect wins over a load-use hold
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall_if) begin
            pc_next = pc;
        end else begin
            pc_next = pc4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= rv_pkg::RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_instr <= rv_pkg::NOP;
        end else if (flush_id) begin
            if_instr <= rv_pkg::NOP;
        end else if (!stall_id) begin
            if_instr <= im_dout;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_id) begin
            if_pc  <= pc;
            if_pc4 <= pc4;
        end
    end

endmodule

/* design/decode_stage.sv */
module decode_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::word_t     if_pc,
    input  rv_pkg::word_t     if_pc4,
    input  rv_pkg::instr_u    if_instr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  logic              bubble,
    input  logic              stall_id,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::id_ex_t    id_ex
);

    rv_pkg::ctrl_t ctrl;
    rv_pkg::word_t imm;
    logic          known_op;

    assign rs1_addr = if_instr.r.rs1;
    assign rs2_addr = if_instr.r.rs2;
    assign known_op = if_instr.r.opcode inside {rv_pkg::OP, rv_pkg::OP_IMM, rv_pkg::LUI,
        rv_pkg::AUIPC, rv_pkg::LOAD, rv_pkg::STORE, rv_pkg::BRANCH, rv_pkg::JAL, rv_pkg::JALR};

    // Zero ctrl means add, writeback from ALU, no side effects
    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (if_instr.r.opcode)
            rv_pkg::OP: begin
                ctrl.alu_op    = rv_pkg::alu_op_e'({if_instr.r.funct7[5], if_instr.r.funct3});
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::OP_IMM: begin
                // Only srai takes instr[30] as an ALU bit
                ctrl.alu_op    = rv_pkg::alu_op_e'({if_instr.i.funct3 == 3'b101 &&
                                                    if_instr.i.imm[10], if_instr.i.funct3});
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {{20{if_instr.i.imm[11]}}, if_instr.i.imm};
            end
            rv_pkg::LUI: begin
                ctrl.alu_op    = rv_pkg::ALU_PASS_B;
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {if_instr.u.imm, 12'b0};
            end
            rv_pkg::AUIPC: begin
                ctrl.a_pc      = 1'b1;
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {if_instr.u.imm, 12'b0};
            end
            rv_pkg::LOAD: begin
                ctrl.b_imm     = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::WB_MEM;
                imm            = {{20{if_instr.i.imm[11]}}, if_instr.i.imm};
            end
            rv_pkg::STORE: begin
                ctrl.b_imm     = 1'b1;
                ctrl.mem_write = 1'b1;
                imm = {{20{if_instr.s.imm_hi[6]}}, if_instr.s.imm_hi, if_instr.s.imm_lo};
            end
            rv_pkg::BRANCH: begin
                ctrl.a_pc  = 1'b1;
                ctrl.b_imm = 1'b1;
                case (if_instr.b.funct3)
                    3'b000:  ctrl.br_type = rv_pkg::BR_EQ;
                    3'b001:  ctrl.br_type = rv_pkg::BR_NE;
                    3'b100:  ctrl.br_type = rv_pkg::BR_LT;
                    3'b101:  ctrl.br_type = rv_pkg::BR_GE;
                    3'b110:  ctrl.br_type = rv_pkg::BR_LTU;
                    3'b111:  ctrl.br_type = rv_pkg::BR_GEU;
                    default: ctrl.br_type = rv_pkg::BR_NONE;
                endcase
                imm = {{19{if_instr.b.imm12}}, if_instr.b.imm12, if_instr.b.imm11,
                       if_instr.b.imm10_5, if_instr.b.imm4_1, 1'b0};
            end
            rv_pkg::JAL: begin
                ctrl.a_pc      = 1'b1;
                ctrl.b_imm     = 1'b1;
                ctrl.jal       = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::WB_PC4;
                imm = {{11{if_instr.j.imm20}}, if_instr.j.imm20, if_instr.j.imm19_12,
                       if_instr.j.imm11, if_instr.j.imm10_1, 1'b0};
            end
            rv_pkg::JALR: begin
                ctrl.b_imm     = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::WB_PC4;
                imm            = {{20{if_instr.i.imm[11]}}, if_instr.i.imm};
            end
            default: ;
        endcase
    end

    // A bubble only needs its ctrl cleared
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex.ctrl <= '0;
        end else if (bubble) begin
            id_ex.ctrl <= '0;
        end else if (!stall_id) begin
            id_ex.ctrl     <= ctrl;
            id_ex.pc       <= if_pc;
            id_ex.pc4      <= if_pc4;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.rs1_addr <= rs1_addr;
            id_ex.rs2_addr <= rs2_addr;
            id_ex.imm      <= imm;
            id_ex.rd       <= if_instr.r.rd;
        end
    end

    a_unknown_op_inert: assert property (@(posedge clk) disable iff (!arst_n)
        !known_op && !bubble && !stall_id |=> !id_ex.ctrl.reg_write && !id_ex.ctrl.mem_write);

endmodule

/* design/reg_file.sv */
module reg_file (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  logic              wr_en,
    input  rv_pkg::reg_addr_t wr_addr,
    input  rv_pkg::word_t     wr_data,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);

    rv_pkg::word_t regs [32];

    // Same-cycle write is visible to the read
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en && wr_addr == addr) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (rs1_addr == '0 |-> rs1_data == '0) and (rs2_addr == '0 |-> rs2_data == '0));

endmodule

/* design/execute_stage.sv */
module execute_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  rv_pkg::id_ex_t   id_ex,
    input  rv_pkg::fwd_sel_e fwd_a,
    input  rv_pkg::fwd_sel_e fwd_b,
    input  rv_pkg::word_t    mem_fwd,
    input  rv_pkg::word_t    wb_fwd,
    output logic             redirect,
    output rv_pkg::word_t    redirect_pc,
    output rv_pkg::ex_mem_t  ex_mem
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t src_a;
    rv_pkg::word_t src_b;
    rv_pkg::word_t alu_y;
    logic          taken;

    function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_sel_e sel,
                                              input rv_pkg::word_t rf_val);
        case (sel)
            rv_pkg::FWD_MEM: return mem_fwd;
            rv_pkg::FWD_WB:  return wb_fwd;
            default:         return rf_val;
        endcase
    endfunction

    always_comb begin
        op_a  = fwd_mux(fwd_a, id_ex.rs1_data);
        op_b  = fwd_mux(fwd_b, id_ex.rs2_data);
        src_a = id_ex.ctrl.a_pc ? id_ex.pc : op_a;
        src_b = id_ex.ctrl.b_imm ? id_ex.imm : op_b;
    end

    always_comb begin
        case (id_ex.ctrl.alu_op)
            rv_pkg::ALU_ADD:    alu_y = src_a + src_b;
            rv_pkg::ALU_SUB:    alu_y = src_a - src_b;
            rv_pkg::ALU_SLL:    alu_y = src_a << src_b[4:0];
            rv_pkg::ALU_SLT:    alu_y = rv_pkg::word_t'($signed(src_a) < $signed(src_b));
            rv_pkg::ALU_SLTU:   alu_y = rv_pkg::word_t'(src_a < src_b);
            rv_pkg::ALU_XOR:    alu_y = src_a ^ src_b;
            rv_pkg::ALU_SRL:    alu_y = src_a >> src_b[4:0];
            rv_pkg::ALU_SRA:    alu_y = $signed(src_a) >>> src_b[4:0];
            rv_pkg::ALU_OR:     alu_y = src_a | src_b;
            rv_pkg::ALU_AND:    alu_y = src_a & src_b;
            rv_pkg::ALU_PASS_B: alu_y = src_b;
            default:            alu_y = '0;
        endcase
    end

    // Compare uses the forwarded registers, not the ALU sources
    always_comb begin
        case (id_ex.ctrl.br_type)
            rv_pkg::BR_EQ:  taken = op_a == op_b;
            rv_pkg::BR_NE:  taken = op_a != op_b;
            rv_pkg::BR_LT:  taken = $signed(op_a) < $signed(op_b);
            rv_pkg::BR_GE:  taken = $signed(op_a) >= $signed(op_b);
            rv_pkg::BR_LTU: taken = op_a < op_b;
            rv_pkg::BR_GEU: taken = op_a >= op_b;
            default:        taken = 1'b0;
        endcase
    end

    assign redirect    = taken || id_ex.ctrl.jal || id_ex.ctrl.jalr;
    assign redirect_pc = id_ex.ctrl.jalr ? {alu_y[31:1], 1'b0} : alu_y;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.reg_write <= 1'b0;
        end else begin
            ex_mem.mem_read   <= id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.wb_sel     <= id_ex.ctrl.wb_sel;
            ex_mem.alu_result <= alu_y;
            ex_mem.store_data <= op_b;
            ex_mem.pc4        <= id_ex.pc4;
            ex_mem.rd         <= id_ex.rd;
        end
    end

    a_target_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |-> redirect_pc[1:0] == 2'b00);

endmodule

/* design/memory_stage.sv */
module memory_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::word_t     dm_dout,
    output rv_pkg::word_t     dm_addr,
    output rv_pkg::word_t     dm_din,
    output logic              dm_re,
    output logic              dm_we,
    output rv_pkg::word_t     mem_fwd,
    output rv_pkg::word_t     wb_fwd,
    output logic              wr_en,
    output rv_pkg::reg_addr_t wr_addr,
    output rv_pkg::word_t     wr_data
);

    rv_pkg::mem_wb_t mem_wb;

    assign dm_addr = ex_mem.alu_result;
    assign dm_din  = ex_mem.store_data;
    assign dm_re   = ex_mem.mem_read;
    assign dm_we   = ex_mem.mem_write;

    // Loads never forward from here, the load-use stall covers them
    assign mem_fwd = (ex_mem.wb_sel == rv_pkg::WB_PC4) ? ex_mem.pc4 : ex_mem.alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb.reg_write <= 1'b0;
        end else begin
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.wb_sel     <= ex_mem.wb_sel;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= dm_dout;
            mem_wb.pc4        <= ex_mem.pc4;
            mem_wb.rd         <= ex_mem.rd;
        end
    end

    always_comb begin
        case (mem_wb.wb_sel)
            rv_pkg::WB_MEM: wr_data = mem_wb.load_data;
            rv_pkg::WB_PC4: wr_data = mem_wb.pc4;
            default:        wr_data = mem_wb.alu_result;
        endcase
    end

    assign wb_fwd  = wr_data;
    assign wr_en   = mem_wb.reg_write;
    assign wr_addr = mem_wb.rd;

    a_one_access: assert property (@(posedge clk) disable iff (!arst_n) !(dm_re && dm_we));

endmodule

/* design/hazard_unit.sv */
module hazard_unit (
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  logic              wr_en,
    input  rv_pkg::reg_addr_t wr_addr,
    input  logic              redirect,
    output rv_pkg::fwd_sel_e  fwd_a,
    output rv_pkg::fwd_sel_e  fwd_b,
    output logic              stall_if,
    output logic              stall_id,
    output logic              bubble,
    output logic              flush_id
);

    logic load_use;

    // MEM result is younger, so it wins over WB
    function automatic rv_pkg::fwd_sel_e pick(input rv_pkg::reg_addr_t src);
        if (src == '0) begin
            return rv_pkg::FWD_RF;
        end else if (ex_mem.reg_write && ex_mem.rd == src) begin
            return rv_pkg::FWD_MEM;
        end else if (wr_en && wr_addr == src) begin
            return rv_pkg::FWD_WB;
        end
        return rv_pkg::FWD_RF;
    endfunction

    always_comb begin
        fwd_a = pick(id_ex.rs1_addr);
        fwd_b = pick(id_ex.rs2_addr);
    end

    assign load_use = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                      (id_ex.rd == rs1_addr || id_ex.rd == rs2_addr);

    // Redirect squashes the dependent instruction anyway
    assign stall_if = load_use && !redirect;
    assign stall_id = stall_if;
    assign bubble   = load_use || redirect;
    assign flush_id = redirect;

    always_comb begin
        a_no_stall_on_redirect: assert final (!(stall_if && redirect))
            else $error("stall_if high during redirect");
    end

endmodule

/* design/rv_core.sv */
module rv_core (
    input  logic          clk,
    input  logic          arst_n,
    output rv_pkg::word_t im_addr,
    input  rv_pkg::word_t im_dout,
    output rv_pkg::word_t dm_addr,
    output rv_pkg::word_t dm_din,
    output logic          dm_re,
    output logic          dm_we,
    input  rv_pkg::word_t dm_dout
);

    rv_pkg::word_t     if_pc;
    rv_pkg::word_t     if_pc4;
    rv_pkg::instr_u    if_instr;
    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::ex_mem_t   ex_mem;
    rv_pkg::fwd_sel_e  fwd_a;
    rv_pkg::fwd_sel_e  fwd_b;
    rv_pkg::word_t     redirect_pc;
    rv_pkg::word_t     mem_fwd;
    rv_pkg::word_t     wb_fwd;
    rv_pkg::reg_addr_t wr_addr;
    rv_pkg::word_t     wr_data;
    logic              wr_en;
    logic              redirect;
    logic              stall_if;
    logic              stall_id;
    logic              bubble;
    logic              flush_id;

    fetch_stage u_fetch (
        .clk, .arst_n, .stall_if, .stall_id, .flush_id, .redirect, .redirect_pc,
        .im_dout, .im_addr, .if_pc, .if_pc4, .if_instr
    );

    decode_stage u_decode (
        .clk, .arst_n, .if_pc, .if_pc4, .if_instr, .rs1_data, .rs2_data,
        .bubble, .stall_id, .rs1_addr, .rs2_addr, .id_ex
    );

    reg_file u_reg_file (
        .clk, .arst_n, .rs1_addr, .rs2_addr, .wr_en, .wr_addr, .wr_data,
        .rs1_data, .rs2_data
    );

    execute_stage u_execute (
        .clk, .arst_n, .id_ex, .fwd_a, .fwd_b, .mem_fwd, .wb_fwd,
        .redirect, .redirect_pc, .ex_mem
    );

    memory_stage u_memory (
        .clk, .arst_n, .ex_mem, .dm_dout, .dm_addr, .dm_din, .dm_re, .dm_we,
        .mem_fwd, .wb_fwd, .wr_en, .wr_addr, .wr_data
    );

    hazard_unit u_hazard (
        .rs1_addr, .rs2_addr, .id_ex, .ex_mem, .wr_en, .wr_addr, .redirect,
        .fwd_a, .fwd_b, .stall_if, .stall_id, .bubble, .flush_id
    );

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int period_ns = 100
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

/* sim/rv_core_tb.sv */
module rv_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic          clk;
    logic          arst_n;
    rv_pkg::word_t im_addr;
    rv_pkg::word_t im_dout;
    rv_pkg::word_t dm_addr;
    rv_pkg::word_t dm_din;
    logic          dm_re;
    logic          dm_we;
    rv_pkg::word_t dm_dout;

    rv_pkg::word_t imem [256];
    rv_pkg::word_t dmem [256];

    // Store stream seen at the data port, and what the ISA predicts
    rv_pkg::word_t st_addr [$];
    rv_pkg::word_t st_data [$];
    rv_pkg::word_t exp_addr [$];
    rv_pkg::word_t exp_data [$];

    int prog_len = 0;
    int checks   = 0;
    int errors   = 0;
    int cycles   = 0;
    int budget   = 0;
    int seed     = 81;

    tb_clock_gen #(.period_ns(100)) u_clk (.clk(clk));

    rv_core UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .im_addr (im_addr),
        .im_dout (im_dout),
        .dm_addr (dm_addr),
        .dm_din  (dm_din),
        .dm_re   (dm_re),
        .dm_we   (dm_we),
        .dm_dout (dm_dout)
    );

    // Both memories answer in the same cycle
    assign im_dout = imem[im_addr[9:2]];
    // Load data is only valid while the core strobes a read
    assign dm_dout = dm_re ? dmem[dm_addr[9:2]] : 'x;

    always @(negedge clk) begin
        if (arst_n && dm_we) begin
            dmem[dm_addr[9:2]] = dm_din;
            st_addr.push_back(dm_addr);
            st_data.push_back(dm_din);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > budget) begin
            errors++;
            $display("ERROR: timeout after %0d cycles, the store stream never completed", cycles);
            finish_run();
        end
    end

    function automatic rv_pkg::word_t rtype(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                            int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::OP};
    endfunction

    function automatic rv_pkg::word_t itype(rv_pkg::opcode_e op, logic [2:0] f3, int rd,
                                            int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    // Word store only
    function automatic rv_pkg::word_t stype(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_pkg::STORE};
    endfunction

    function automatic rv_pkg::word_t btype(logic [2:0] f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], rv_pkg::BRANCH};
    endfunction

    function automatic rv_pkg::word_t utype(rv_pkg::opcode_e op, int rd, logic [19:0] imm);
        return {imm, rd[4:0], op};
    endfunction

    function automatic rv_pkg::word_t jtype(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_pkg::JAL};
    endfunction

    // RV32I register-register results in the order of the ALU test
    function automatic rv_pkg::word_t rv32i_alu(int k, rv_pkg::word_t a, rv_pkg::word_t b);
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return rv_pkg::word_t'($signed(a) >>> b[4:0]);
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_rule(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic rv_pkg::word_t here();
        return rv_pkg::word_t'(prog_len * 4);
    endfunction

    task automatic emit(rv_pkg::word_t instr);
        imem[prog_len] = instr;
        prog_len++;
        budget += 40;
    endtask

    // Upper part rounded for the sign of the low 12 bits
    task automatic load_const(int rd, rv_pkg::word_t v);
        rv_pkg::word_t hi;
        hi = (v + 32'h800) >> 12;
        emit(utype(rv_pkg::LUI, rd, hi[19:0]));
        emit(itype(rv_pkg::OP_IMM, 3'b000, rd, rd, v));
    endtask

    task automatic expect_store(rv_pkg::word_t addr, rv_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_word(string name, rv_pkg::word_t expected, rv_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("FAILED %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // Core goes into reset before its program is replaced
    task automatic start_test();
        if (arst_n) begin
            @(posedge clk);
            #5;
            arst_n = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            imem[i] = itype(rv_pkg::OP_IMM, 3'b000, 0, 0, i);
        end
        prog_len = 0;
        st_addr.delete();
        st_data.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic run_test(string name);
        repeat (8) @(posedge clk);
        #5;
        arst_n = 1'b1;
        while (st_addr.size() < exp_addr.size()) @(negedge clk);
        // Window for any store that should have been flushed
        repeat (6) @(negedge clk);
        check_count({name, " store count"}, exp_addr.size(), st_addr.size());
        for (int k = 0; k < exp_addr.size() && k < st_addr.size(); k++) begin
            check_word($sformatf("%s dm_addr #%0d", name, k), exp_addr[k], st_addr[k]);
            check_word($sformatf("%s dm_din #%0d", name, k), exp_data[k], st_data[k]);
        end
    endtask

    task automatic test_alu();
        logic [2:0]    f3_tab [10];
        logic [6:0]    f7_tab [10];
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        f3_tab = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        f7_tab = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
        start_test();
        // Opposite signs and a nonzero shift amount keep signed and unsigned results apart
        a = $random(seed) | 32'h8000_0000;
        b = ($random(seed) & 32'h7fff_ffff) | 32'h1;
        load_const(1, a);
        load_const(2, b);
        emit(itype(rv_pkg::OP_IMM, 3'b000, 10, 0, 'h100));
        for (int k = 0; k < 10; k++) begin
            emit(rtype(f7_tab[k], f3_tab[k], 11 + k, 1, 2));
        end
        for (int k = 0; k < 10; k++) begin
            emit(stype(11 + k, 10, 4 * k));
            expect_store(32'h100 + 4 * k, rv32i_alu(k, a, b));
        end
        emit(jtype(0, 0));
        run_test("alu");
    endtask

    task automatic test_forwarding();
        rv_pkg::word_t c;
        rv_pkg::word_t d;
        rv_pkg::word_t r3;
        rv_pkg::word_t r4;
        rv_pkg::word_t r5;
        rv_pkg::word_t r6;
        start_test();
        c = $random(seed);
        d = $random(seed);
        r3 = c + d;
        r4 = r3 + r3;
        r5 = r4 + c;
        r6 = r5 + d;
        load_const(1, c);
        load_const(2, d);
        emit(itype(rv_pkg::OP_IMM, 3'b000, 10, 0, 'h180));
        emit(rtype(7'h00, 3'b000, 3, 1, 2));
        emit(rtype(7'h00, 3'b000, 4, 3, 3));
        emit(itype(rv_pkg::OP_IMM, 3'b000, 0, 0, 0));
        emit(rtype(7'h00, 3'b000, 5, 4, 1));
        emit(itype(rv_pkg::OP_IMM, 3'b000, 0, 0, 0));
        emit(itype(rv_pkg::OP_IMM, 3'b000, 0, 0, 0));
        emit(rtype(7'h00, 3'b000, 6, 5, 2));
        // Store data taken straight from the previous add
        emit(stype(6, 10, 12));
        emit(stype(3, 10, 0));
        emit(stype(4, 10, 4));
        emit(stype(5, 10, 8));
        expect_store(32'h18c, r6);
        expect_store(32'h180, r3);
        expect_store(32'h184, r4);
        expect_store(32'h188, r5);
        emit(jtype(0, 0));
        run_test("forwarding");
    endtask

    task automatic test_load_use();
        rv_pkg::word_t w;
        rv_pkg::word_t k;
        start_test();
        w = $random(seed);
        k = $random(seed);
        load_const(1, w);
        load_const(4, k);
        emit(itype(rv_pkg::OP_IMM, 3'b000, 10, 0, 'h200));
        emit(stype(1, 10, 0));
        emit(itype(rv_pkg::LOAD, 3'b010, 2, 10, 0));
        emit(rtype(7'h00, 3'b000, 3, 2, 4));
        emit(stype(3, 10, 4));
        emit(itype(rv_pkg::LOAD, 3'b010, 5, 10, 0));
        emit(stype(5, 10, 8));
        // One slot after the load so the sum comes from WB
        emit(itype(rv_pkg::LOAD, 3'b010, 6, 10, 4));
        emit(itype(rv_pkg::OP_IMM, 3'b000, 0, 0, 0));
        emit(rtype(7'h00, 3'b000, 7, 6, 6));
        emit(stype(7, 10, 12));
        expect_store(32'h200, w);
        expect_store(32'h204, w + k);
        expect_store(32'h208, w);
        expect_store(32'h20c, (w + k) + (w + k));
        emit(jtype(0, 0));
        run_test("load-use");
    endtask

    task automatic test_branches();
        logic [2:0]    conds [6];
        int            pair_a [3];
        int            pair_b [3];
        rv_pkg::word_t regv [8];
        int            n;
        conds  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        pair_a = '{5, 6, 6};
        pair_b = '{6, 5, 7};
        start_test();
        // Opposite signs make signed and unsigned compares disagree
        regv[5] = $random(seed) | 32'h8000_0000;
        regv[6] = $random(seed) & 32'h7fff_ffff;
        regv[7] = regv[6];
        load_const(5, regv[5]);
        load_const(6, regv[6]);
        emit(itype(rv_pkg::OP_IMM, 3'b000, 7, 6, 0));
        emit(itype(rv_pkg::OP_IMM, 3'b000, 20, 0, 'h111));
        emit(itype(rv_pkg::OP_IMM, 3'b000, 21, 0, 'h222));
        emit(itype(rv_pkg::OP_IMM, 3'b000, 10, 0, 'h280));
        n = 0;
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                emit(btype(conds[c], pair_a[p], pair_b[p], 12));
                emit(stype(20, 10, 4 * n));
                emit(jtype(0, 8));
                emit(stype(21, 10, 4 * n));
                expect_store(32'h280 + 4 * n,
                             branch_rule(conds[c], regv[pair_a[p]], regv[pair_b[p]]) ?
                             32'h222 : 32'h111);
                n++;
            end
        end
        emit(jtype(0, 0));
        run_test("branch");
    endtask

    task automatic test_jumps();
        rv_pkg::word_t u;
        rv_pkg::word_t link_j;
        rv_pkg::word_t link_r;
        rv_pkg::word_t pc_a;
        rv_pkg::word_t target;
        start_test();
        u = $random(seed);
        emit(itype(rv_pkg::OP_IMM, 3'b000, 10, 0, 'h300));
        link_j = here() + 4;
        emit(jtype(1, 8));
        emit(stype(0, 10, 'h40));
        emit(stype(1, 10, 0));
        expect_store(32'h300, link_j);
        pc_a = here();
        emit(utype(rv_pkg::AUIPC, 2, u[19:0]));
        emit(stype(2, 10, 4));
        expect_store(32'h304, pc_a + {u[19:0], 12'b0});
        // Odd base, and the auipc at the target reports the PC it was fetched from
        target = here() + 12;
        emit(itype(rv_pkg::OP_IMM, 3'b000, 3, 0, target + 1));
        link_r = here() + 4;
        emit(itype(rv_pkg::JALR, 3'b000, 4, 3, 0));
        emit(stype(0, 10, 'h44));
        emit(utype(rv_pkg::AUIPC, 5, 20'h0));
        emit(stype(4, 10, 8));
        emit(stype(5, 10, 12));
        expect_store(32'h308, link_r);
        expect_store(32'h30c, target);
        emit(jtype(0, 0));
        run_test("jump");
    endtask

    initial begin
        arst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hc0de_0000 ^ (rv_pkg::word_t'(i) * 32'h0001_0101);
            imem[i] = itype(rv_pkg::OP_IMM, 3'b000, 0, 0, i);
        end
        test_alu();
        test_forwarding();
        test_load_use();
        test_branches();
        test_jumps();
        finish_run();
    end

endmodule

/* filelist.f */
design/rv_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/memory_stage.sv
design/hazard_unit.sv
design/rv_core.sv
sim/tb_clock_gen.sv
sim/rv_core_tb.sv
